//--- common/core4t_config.svh
////////////////////
// Core sizing macros
// Thread count, widths, reset PC stride, NOP
////////////////////
`ifndef CORE4T_CONFIG_SVH
`define CORE4T_CONFIG_SVH

// Barrel geometry
`define CORE_THREADS   4             // Hardware threads in rotation
`define CORE_REGS      16            // Registers per thread bank

// Datapath
`define CORE_XLEN      32            // Data and address width

// Per-thread program placement
`define CORE_PC_STRIDE 32'h400       // Thread i resets to i times this

// Bubble encoding
`define CORE_NOP       32'h0000_0013 // ADDI writing x0

`endif

//--- common/rv32IsaPkg.sv
////////////////////
// RV32I opcode, ALU operation and decode control types
////////////////////
`default_nettype none

package rv32IsaPkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuiPc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opOpImm  = 7'b0010011,
        opOp     = 7'b0110011
    } opcodeT;

    // ALU operation, {funct7[5], funct3}
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSll  = 4'b0001,
        aluSlt  = 4'b0010,
        aluSltu = 4'b0011,
        aluXor  = 4'b0100,
        aluSrl  = 4'b0101,
        aluOr   = 4'b0110,
        aluAnd  = 4'b0111,
        aluSub  = 4'b1000,
        aluSra  = 4'b1101
    } aluOpT;

    // Decode flags, produced at Q101H
    typedef struct packed {
        logic jal;
        logic jalr;
        logic branch;
        logic iTypeImm;  // Second operand is the I immediate
        logic lui;
        logic auiPc;
        logic store;     // Second operand is the S immediate
        logic memRd;
        logic memWr;
        logic memToReg;  // Writeback from data memory
        logic pcToReg;   // Writeback of the link value
        logic regWr;
    } ctrlT;

    typedef logic [31:0] instrT;

endpackage

`default_nettype wire

//--- common/core4tPkg.sv
////////////////////
// Core types
// Threads, stage payloads, memory and config requests
////////////////////
`include "core4t_config.svh"
`default_nettype none

package core4tPkg;

    typedef logic [`CORE_THREADS-1:0] threadOneHotT;  // One bit per thread
    typedef logic [`CORE_XLEN-1:0]    wordT;
    typedef logic [4:0]               regPtrT;        // Low bits address a bank

    // Q101H slot, instruction joins from the fetch port
    typedef struct packed {
        logic              valid;
        threadOneHotT      thread;
        wordT              pc;
        rv32IsaPkg::instrT instr;
    } q101T;

    // Q102H slot after decode and register read
    typedef struct packed {
        q101T             base;
        rv32IsaPkg::ctrlT ctrl;
        wordT             rs1Data;
        wordT             rs2Data;
    } q102T;

    // Q103H slot, also carried into Q104H
    typedef struct packed {
        logic             valid;
        threadOneHotT     thread;
        wordT             pcPlus4;    // Link value
        wordT             aluOut;     // Result or data address
        wordT             storeData;
        regPtrT           rd;
        rv32IsaPkg::ctrlT ctrl;
    } q103T;

    // Data memory request
    typedef struct packed {
        wordT address;
        wordT writeData;
        logic read;
        logic write;
    } memReqT;

    // Thread-enable write, four-phase
    typedef struct packed {
        logic         req;
        threadOneHotT enableMask;
    } cfgReqT;

    // Register file write port
    typedef struct packed {
        logic         we;
        threadOneHotT thread;
        regPtrT       rd;
        wordT         data;
    } wbT;

endpackage

`default_nettype wire

//--- core/threadControl.sv
////////////////////
// Thread-enable register with req/ack write port
////////////////////
`timescale 1ns/100ps
`default_nettype none

module threadControl (
    input  logic                    QClk,
    input  logic                    reset,
    input  core4tPkg::cfgReqT       cfgReq,
    output logic                    cfgAck,
    output core4tPkg::threadOneHotT enableMask
);

    logic reqRise;

    // Rising edge of req
    // Ack low means the previous handshake has closed
    assign reqRise = cfgReq.req && !cfgAck;

    ////////////////////
    // Handshake and mask
    ////////////////////
    always_ff @(posedge QClk) begin
        if (reset) begin
            cfgAck     <= 1'b0;
            enableMask <= '0;            // All threads parked
        end else begin
            cfgAck <= cfgReq.req;        // Follows req one cycle later, both ways
            if (reqRise) begin
                enableMask <= cfgReq.enableMask;  // Sampled once per request
            end
        end
    end

endmodule

`default_nettype wire

//--- core/threadScheduler.sv
////////////////////
// Thread rotation, per-thread PCs
// Fetch-slot valid
////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "core4t_config.svh"

module threadScheduler (
    input  logic                    QClk,
    input  logic                    reset,
    input  core4tPkg::threadOneHotT enableMask,
    input  core4tPkg::wordT         nextPc,      // From Q102H
    input  core4tPkg::threadOneHotT q102Thread,
    input  logic                    q102Valid,
    output core4tPkg::wordT         pc,          // Q100H
    output logic                    fetchValid,
    output core4tPkg::threadOneHotT fetchThread
);
    import core4tPkg::*;

    wordT threadPc [`CORE_THREADS];

    // Rotation 0, 1, 2, 3, thread 0 first after reset
    always_ff @(posedge QClk) begin
        if (reset) begin
            fetchThread <= threadOneHotT'(1);
        end else begin
            fetchThread <= {fetchThread[`CORE_THREADS-2:0], fetchThread[`CORE_THREADS-1]};
        end
    end

    ////////////////////
    // Program counters
    ////////////////////
    for (genvar t = 0; t < `CORE_THREADS; t++) begin : genPc
        always_ff @(posedge QClk) begin
            if (reset) begin
                threadPc[t] <= wordT'(t * `CORE_PC_STRIDE);  // Separate program per thread
            end else if (q102Valid && q102Thread[t]) begin
                threadPc[t] <= nextPc;   // Two cycles ahead of this thread's next fetch
            end
        end
    end

    // One-hot select of the fetching thread
    always_comb begin
        pc = '0;
        for (int t = 0; t < `CORE_THREADS; t++) begin
            if (fetchThread[t]) pc = threadPc[t];
        end
    end

    assign fetchValid = |(fetchThread & enableMask);  // Disabled slot is a bubble

endmodule

`default_nettype wire

//--- core/decodeStage.sv
////////////////////
// Q101H field extraction and control decode
////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "core4t_config.svh"

module decodeStage (
    input  rv32IsaPkg::instrT instr,
    input  logic              valid,
    output rv32IsaPkg::ctrlT  ctrl,
    output core4tPkg::regPtrT rs1,
    output core4tPkg::regPtrT rs2
);
    import rv32IsaPkg::*;

    instrT  instrQ101H;
    opcodeT opcode;

    // Bubble slots decode as NOP
    // rd is x0 and no memory flag is set
    assign instrQ101H = valid ? instr : `CORE_NOP;
    assign opcode     = opcodeT'(instrQ101H[6:0]);

    assign rs1 = instrQ101H[19:15];  // R/I/S/B
    assign rs2 = instrQ101H[24:20];  // R/S/B

    ////////////////////
    // Control flags
    ////////////////////
    always_comb begin
        ctrl = '0;
        // Control flow
        ctrl.jal      = (opcode == opJal);
        ctrl.jalr     = (opcode == opJalr);
        ctrl.branch   = (opcode == opBranch);
        ctrl.pcToReg  = (opcode == opJal) || (opcode == opJalr);  // Link
        // Operand select
        ctrl.iTypeImm = (opcode == opOpImm) || (opcode == opLoad) || (opcode == opJalr);
        ctrl.lui      = (opcode == opLui);
        ctrl.auiPc    = (opcode == opAuiPc);
        ctrl.store    = (opcode == opStore);
        // Memory
        ctrl.memRd    = (opcode == opLoad);
        ctrl.memWr    = (opcode == opStore);
        ctrl.memToReg = (opcode == opLoad);
        // Every class but stores and branches writes rd
        ctrl.regWr    = !((opcode == opStore) || (opcode == opBranch));
    end

endmodule

`default_nettype wire

//--- core/registerFile.sv
////////////////////
// Four banks of 16 registers
// Read at Q101H, written at Q104H
////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "core4t_config.svh"

module registerFile (
    input  logic                    QClk,
    input  logic                    reset,
    input  core4tPkg::threadOneHotT readThread,  // Q101H thread
    input  core4tPkg::regPtrT       rs1,
    input  core4tPkg::regPtrT       rs2,
    input  core4tPkg::wbT           wb,          // Q104H write
    output core4tPkg::wordT         rd1,
    output core4tPkg::wordT         rd2
);
    import core4tPkg::*;

    localparam int ptrBits = $clog2(`CORE_REGS);  // Bank index width

    wordT bank [`CORE_THREADS][`CORE_REGS];

    // Combinational read from the Q101H bank
    always_comb begin
        rd1 = '0;
        rd2 = '0;
        for (int t = 0; t < `CORE_THREADS; t++) begin
            if (readThread[t]) begin
                rd1 = bank[t][rs1[ptrBits-1:0]];
                rd2 = bank[t][rs2[ptrBits-1:0]];
            end
        end
    end

    ////////////////////
    // Write port
    ////////////////////
    always_ff @(posedge QClk) begin
        if (reset) begin
            for (int t = 0; t < `CORE_THREADS; t++) begin
                for (int r = 0; r < `CORE_REGS; r++) begin
                    bank[t][r] <= '0;
                end
            end
        end else if (wb.we) begin
            for (int t = 0; t < `CORE_THREADS; t++) begin
                // x0 is never written so it stays zero
                if (wb.thread[t] && (wb.rd[ptrBits-1:0] != '0)) begin
                    bank[t][wb.rd[ptrBits-1:0]] <= wb.data;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- core/executeStage.sv
////////////////////
// Q102H immediates, ALU, branch compare
// Next-PC select
////////////////////
`timescale 1ns/100ps
`default_nettype none

module executeStage (
    input  core4tPkg::q102T stage,
    output core4tPkg::wordT aluOut,
    output core4tPkg::wordT nextPc,
    output core4tPkg::wordT pcPlus4
);
    import rv32IsaPkg::*;
    import core4tPkg::*;

    instrT      ins;
    opcodeT     opcode;
    logic [2:0] funct3;
    ctrlT       ctrl;
    wordT       pcQ102H;
    wordT       immI, immS, immB, immU, immJ;
    wordT       aluIn1, aluIn2;
    logic [4:0] shamt;
    aluOpT      aluOp;
    logic       condMet;

    assign ins     = stage.base.instr;
    assign pcQ102H = stage.base.pc;
    assign ctrl    = stage.ctrl;
    assign opcode  = opcodeT'(ins[6:0]);
    assign funct3  = ins[14:12];

    ////////////////////
    // Immediates
    ////////////////////
    assign immI = {{20{ins[31]}}, ins[31:20]};
    assign immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    assign immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    assign immU = {ins[31:12], 12'b0};
    assign immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};

    // Operand select, first match wins
    always_comb begin
        aluIn1 = stage.rs1Data;
        aluIn2 = stage.rs2Data;       // OP and branches
        if (ctrl.lui) begin
            aluIn1 = '0;
            aluIn2 = immU;
        end else if (ctrl.auiPc) begin
            aluIn1 = pcQ102H;
            aluIn2 = immU;
        end else if (ctrl.iTypeImm) begin
            aluIn2 = immI;            // OP-IMM, LW, JALR
        end else if (ctrl.store) begin
            aluIn2 = immS;
        end
    end

    // ALU op from funct7[5] only for OP and immediate shifts
    always_comb begin
        aluOp = aluAdd;               // Address and upper-immediate adds
        if ((opcode == opOp) || ((opcode == opOpImm) && (funct3[1:0] == 2'b01))) begin
            aluOp = aluOpT'({ins[30], funct3});
        end else if (opcode == opOpImm) begin
            aluOp = aluOpT'({1'b0, funct3});
        end
    end

    ////////////////////
    // ALU
    ////////////////////
    assign shamt = aluIn2[4:0];

    always_comb begin
        case (aluOp)
            aluAdd:  aluOut = aluIn1 + aluIn2;
            aluSub:  aluOut = aluIn1 - aluIn2;
            aluSlt:  aluOut = wordT'($signed(aluIn1) < $signed(aluIn2));
            aluSltu: aluOut = wordT'(aluIn1 < aluIn2);
            aluSll:  aluOut = aluIn1 << shamt;
            aluSrl:  aluOut = aluIn1 >> shamt;
            aluSra:  aluOut = $signed(aluIn1) >>> shamt;
            aluXor:  aluOut = aluIn1 ^ aluIn2;
            aluOr:   aluOut = aluIn1 | aluIn2;
            aluAnd:  aluOut = aluIn1 & aluIn2;
            default: aluOut = '0;     // Undefined funct7 combination
        endcase
    end

    // Branch compare on rs1 and rs2
    always_comb begin
        case (funct3)
            3'b000:  condMet = (aluIn1 == aluIn2);                   // BEQ
            3'b001:  condMet = (aluIn1 != aluIn2);                   // BNE
            3'b100:  condMet = ($signed(aluIn1) < $signed(aluIn2));  // BLT
            3'b101:  condMet = ($signed(aluIn1) >= $signed(aluIn2)); // BGE
            3'b110:  condMet = (aluIn1 < aluIn2);                    // BLTU
            3'b111:  condMet = (aluIn1 >= aluIn2);                   // BGEU
            default: condMet = 1'b0;
        endcase
    end

    ////////////////////
    // Next PC
    ////////////////////
    assign pcPlus4 = pcQ102H + 32'd4;

    always_comb begin
        nextPc = pcPlus4;
        if (ctrl.jalr) begin
            nextPc = {aluOut[31:1], 1'b0};   // rs1 plus imm, LSB cleared
        end else if (ctrl.jal) begin
            nextPc = pcQ102H + immJ;
        end else if (ctrl.branch && condMet) begin
            nextPc = pcQ102H + immB;
        end
    end

endmodule

`default_nettype wire

//--- core/core4t.sv
////////////////////
// Four-thread barrel RV32I core
// Stage registers, memory stage, writeback
////////////////////
`timescale 1ns/100ps
`default_nettype none

module core4t (
    input  logic                QClk,
    input  logic                reset,
    // Instruction memory
    output core4tPkg::wordT     pc,          // Q100H
    output logic                fetchValid,
    input  rv32IsaPkg::instrT   instr,       // Q101H
    // Data memory
    output core4tPkg::memReqT   dataReq,     // Q103H
    input  core4tPkg::wordT     readData,    // Q104H
    // Thread enable
    input  core4tPkg::cfgReqT   cfgReq,
    output logic                cfgAck
);
    import rv32IsaPkg::*;
    import core4tPkg::*;

    threadOneHotT enableMask;
    threadOneHotT threadQ100H, threadQ101H;
    logic         validQ101H;
    wordT         pcQ101H;
    q101T         q101;
    ctrlT         ctrlQ101H;
    regPtrT       rs1Q101H, rs2Q101H;
    wordT         rd1Q101H, rd2Q101H;
    q102T         q102Q;
    wordT         aluOutQ102H, nextPcQ102H, pcPlus4Q102H;
    q103T         q103Q, q104Q;
    wordT         wbDataQ104H;
    wbT           wbQ104H;

    ////////////////////
    // Q100H fetch
    ////////////////////
    threadControl i_threadControl (
        .QClk(QClk), .reset(reset), .cfgReq(cfgReq),
        .cfgAck(cfgAck), .enableMask(enableMask)
    );

    threadScheduler i_threadScheduler (
        .QClk(QClk), .reset(reset), .enableMask(enableMask),
        .nextPc(nextPcQ102H), .q102Thread(q102Q.base.thread), .q102Valid(q102Q.base.valid),
        .pc(pc), .fetchValid(fetchValid), .fetchThread(threadQ100H)
    );

    always_ff @(posedge QClk) begin
        threadQ101H <= threadQ100H;
        pcQ101H     <= pc;
        validQ101H  <= reset ? 1'b0 : fetchValid;
    end

    ////////////////////
    // Q101H decode and register read
    ////////////////////
    assign q101 = '{valid: validQ101H, thread: threadQ101H, pc: pcQ101H, instr: instr};

    decodeStage i_decodeStage (
        .instr(q101.instr), .valid(q101.valid),
        .ctrl(ctrlQ101H), .rs1(rs1Q101H), .rs2(rs2Q101H)
    );

    registerFile i_registerFile (
        .QClk(QClk), .reset(reset), .readThread(q101.thread),
        .rs1(rs1Q101H), .rs2(rs2Q101H), .wb(wbQ104H),
        .rd1(rd1Q101H), .rd2(rd2Q101H)
    );

    always_ff @(posedge QClk) begin
        q102Q <= '{base: q101, ctrl: ctrlQ101H, rs1Data: rd1Q101H, rs2Data: rd2Q101H};
        if (reset) q102Q.base.valid <= 1'b0;
    end

    ////////////////////
    // Q102H execute
    ////////////////////
    executeStage i_executeStage (
        .stage(q102Q),
        .aluOut(aluOutQ102H), .nextPc(nextPcQ102H), .pcPlus4(pcPlus4Q102H)
    );

    always_ff @(posedge QClk) begin
        q103Q <= '{valid: q102Q.base.valid, thread: q102Q.base.thread,
                   pcPlus4: pcPlus4Q102H, aluOut: aluOutQ102H, storeData: q102Q.rs2Data,
                   rd: q102Q.base.instr[11:7], ctrl: q102Q.ctrl};
        if (reset) q103Q.valid <= 1'b0;
    end

    // Q103H memory request, strobes only for live slots
    assign dataReq = '{address:   q103Q.aluOut,
                       writeData: q103Q.storeData,
                       read:      q103Q.valid && q103Q.ctrl.memRd,
                       write:     q103Q.valid && q103Q.ctrl.memWr};

    always_ff @(posedge QClk) begin
        q104Q <= q103Q;
        if (reset) q104Q.valid <= 1'b0;
    end

    ////////////////////
    // Q104H writeback
    ////////////////////
    always_comb begin
        if (q104Q.ctrl.memToReg) wbDataQ104H = readData;           // LW
        else if (q104Q.ctrl.pcToReg) wbDataQ104H = q104Q.pcPlus4;  // JAL, JALR link
        else wbDataQ104H = q104Q.aluOut;
    end

    assign wbQ104H = '{we: q104Q.valid && q104Q.ctrl.regWr, thread: q104Q.thread,
                       rd: q104Q.rd, data: wbDataQ104H};

endmodule

`default_nettype wire

//--- sim/clockGen.sv
////////////////////
// Testbench clock and reset
////////////////////
`timescale 1ns/100ps
`default_nettype none

module clockGen (
    output logic QClk,
    output logic reset
);

    initial begin
        QClk = 1'b0;
        forever #4 QClk = ~QClk;  // 8 ns period
    end

    // Reset for 5 cycles, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge QClk);
        @(negedge QClk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- sim/core4t_assertions.sv
////////////////////
// Concurrent checks on core4t ports
////////////////////
`timescale 1ns/100ps
`default_nettype none

module core4t_assertions (
    input logic                QClk,
    input logic                reset,
    input logic                fetchValid,
    input core4tPkg::wordT     pc,
    input core4tPkg::memReqT   dataReq,
    input core4tPkg::cfgReqT   cfgReq,
    input logic                cfgAck
);

    // Strobes idle right after reset
    assert property (@(posedge QClk) reset |=> !(dataReq.read || dataReq.write))
        else $error("memory strobe active after reset");

    // Only aligned accesses on the word-wide data port
    assert property (@(posedge QClk)
        (dataReq.read || dataReq.write) |-> (dataReq.address[1:0] == 2'b00))
        else $error("misaligned data access");

    // Ack follows req one cycle later in both directions
    assert property (@(posedge QClk) disable iff (reset) cfgReq.req |=> cfgAck)
        else $error("cfgAck did not rise");
    assert property (@(posedge QClk) disable iff (reset) !cfgReq.req |=> !cfgAck)
        else $error("cfgAck did not fall");

    assert property (@(posedge QClk) fetchValid |-> (pc[1:0] == 2'b00))
        else $error("misaligned fetch");  // Word fetches only

endmodule

bind core4t core4t_assertions i_core4t_assertions (
    .QClk(QClk), .reset(reset), .fetchValid(fetchValid), .pc(pc),
    .dataReq(dataReq), .cfgReq(cfgReq), .cfgAck(cfgAck)
);

`default_nettype wire

//--- sim/core4t_tb.sv
////////////////////
// core4t testbench
// Memories, programs, ISA reference model, checks, watchdog
////////////////////
`timescale 1ns/100ps
`default_nettype none
`include "core4t_config.svh"

module core4t_tb;
    import rv32IsaPkg::*;
    import core4tPkg::*;

    localparam instrT haltInstr = 32'h0000_006f;  // JAL x0, 0

    logic   QClk, reset, cfgAck, fetchValid;
    wordT   pc, lastPc, lastAddr;
    logic   lastRead = 1'b0;
    instrT  instr = `CORE_NOP;
    wordT   readData = '0;
    cfgReqT cfgReq = '0;
    memReqT dataReq;

    instrT  imem [0:4095];
    wordT   dataMem [wordT];
    wordT   refMem [wordT];
    memReqT expQ [`CORE_THREADS][$];     // Expected stores per thread
    threadOneHotT activeMask = '0;
    int     writePtr, storeOff, maxInstr, watchdogCycles = 0;

    clockGen i_clockGen (.QClk(QClk), .reset(reset));

    core4t i_core4t (
        .QClk(QClk), .reset(reset), .pc(pc), .fetchValid(fetchValid), .instr(instr),
        .dataReq(dataReq), .readData(readData), .cfgReq(cfgReq), .cfgAck(cfgAck)
    );

    ////////////////////
    // Failure reporting
    ////////////////////
    task automatic abortRun();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkStore(memReqT expected, memReqT got);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: store got %h/%h exp %h/%h", $time,
                     got.address, got.writeData, expected.address, expected.writeData);
            abortRun();
        end
    endtask

    task automatic checkConfig(threadOneHotT mask, logic expAck);
        if (cfgAck !== expAck) begin
            $display("CHECK FAILED at %0t: cfgAck %b exp %b, mask %b", $time,
                     cfgAck, expAck, mask);
            abortRun();
        end
    endtask

    ////////////////////
    // Encoders
    ////////////////////
    function automatic instrT encR(logic alt, int rs2, int rs1, logic [2:0] f3, int rd);
        return {1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic instrT encI(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                   logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic instrT encB(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic instrT encU(logic [19:0] imm, int rd, logic [6:0] op);
        return {imm, 5'(rd), op};
    endfunction

    function automatic instrT encJ(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic emit(instrT w);
        imem[writePtr] = w;
        writePtr++;
    endtask

    task automatic storeReg(int r);  // SW r, storeOff(x15)
        emit({storeOff[11:5], 5'(r), 5'd15, 3'b010, storeOff[4:0], 7'b0100011});
        storeOff += 4;
    endtask

    ////////////////////
    // Program builder
    ////////////////////
    task automatic buildProgram(int t);
        logic [31:0] r;
        int ra, rb, base;
        logic [2:0] bf [6];
        bf = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        base = t * (`CORE_PC_STRIDE / 4);
        writePtr = base;
        storeOff = 0;
        emit(encU(20'(16 + t), 15, 7'b0110111));        // Data region 0x10000 + t*0x1000
        for (int round = 0; round < 2; round++) begin
            for (int k = 1; k <= 6; k++) begin          // Random register values
                r = $urandom();
                emit(encU(r[31:12], k, 7'b0110111));
                emit(encI(r[11:0], k, 3'd0, k, 7'b0010011));
            end
            for (int k = 0; k < 10; k++) begin          // R type incl. SUB, SRA
                r = $urandom();
                emit(encR(k >= 8, 1 + int'(r[2:0]) % 6, 1 + int'(r[6:4]) % 6,
                          (k == 9) ? 3'd5 : 3'(k % 8), 7));
                storeReg(7);
            end
            for (int k = 0; k < 9; k++) begin           // OP-IMM incl. SRAI
                r = $urandom();
                if (k == 1 || k == 5) r[11:5] = 7'b0;
                if (k == 8) r[11:5] = 7'b0100000;
                emit(encI(r[11:0], 1 + int'(r[14:12]) % 6, (k == 8) ? 3'd5 : 3'(k), 7,
                          7'b0010011));
                storeReg(7);
            end
            r = $urandom();
            emit(encU(r[19:0], 8, 7'b0010111));         // AUIPC
            storeReg(8);
            for (int k = 0; k < 6; k++) begin           // Taken stores 2, else 3
                r = $urandom();
                ra = 1 + int'(r[2:0]) % 6;
                rb = (round == 1) ? ra : 1 + int'(r[6:4]) % 6;
                emit(encI(12'd0, 0, 3'd0, 9, 7'b0010011));
                emit(encB(13'd8, rb, ra, bf[k]));
                emit(encI(12'd1, 9, 3'd0, 9, 7'b0010011));
                emit(encI(12'd2, 9, 3'd0, 9, 7'b0010011));
                storeReg(9);
            end
            emit(encJ(21'd8, 10));                      // JAL over one
            emit(encI(12'd1, 0, 3'd0, 11, 7'b0010011));
            storeReg(10);
            emit(encU(20'd0, 12, 7'b0010111));
            emit(encI(12'd12, 12, 3'd0, 13, 7'b1100111)); // JALR over one
            emit(encI(12'd1, 0, 3'd0, 11, 7'b0010011));
            storeReg(13);
            emit(encI(12'(storeOff - 4), 15, 3'd2, 14, 7'b0000011));  // LW back
            storeReg(14);
            emit(encI(12'd5, 1, 3'd0, 0, 7'b0010011));  // Write to x0
            storeReg(0);
        end
        emit(haltInstr);
        if (writePtr - base > maxInstr) maxInstr = writePtr - base;
    endtask

    ////////////////////
    // ISA reference model
    ////////////////////
    function automatic wordT aluRef(logic [2:0] f3, logic alt, wordT a, wordT b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchRef(logic [2:0] f3, wordT a, wordT b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic void runReference(int t);
        wordT x [16];
        wordT pcR, nextPc, a, b, immI, immS, res;
        instrT ins;
        logic wr;
        for (int k = 0; k < 16; k++) x[k] = '0;
        pcR = wordT'(t * `CORE_PC_STRIDE);
        for (int step = 0; step < 2000; step++) begin
            ins = imem[pcR[13:2]];
            if (ins == haltInstr) break;
            a = x[ins[18:15]];
            b = x[ins[23:20]];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            nextPc = pcR + 4;
            wr = 1'b1;
            res = '0;
            case (ins[6:0])
                7'b0110111: res = {ins[31:12], 12'b0};
                7'b0010111: res = pcR + {ins[31:12], 12'b0};
                7'b1101111: begin
                    res = pcR + 4;
                    nextPc = pcR + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'b1100111: begin
                    res = pcR + 4;
                    nextPc = (a + immI) & ~32'd1;
                end
                7'b1100011: begin
                    wr = 1'b0;
                    if (branchRef(ins[14:12], a, b))
                        nextPc = pcR + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                7'b0000011: res = refMem.exists(a + immI) ? refMem[a + immI] : '0;
                7'b0100011: begin
                    wr = 1'b0;
                    refMem[a + immS] = b;
                    expQ[t].push_back(memReqT'{address: a + immS, writeData: b, read: 1'b0,
                                               write: 1'b1});
                end
                7'b0010011: res = aluRef(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, immI);
                default:    res = aluRef(ins[14:12], ins[30], a, b);
            endcase
            if (wr && ins[10:7] != 4'd0) x[ins[10:7]] = res;
            pcR = nextPc;
        end
    endfunction

    ////////////////////
    // Memory models
    ////////////////////
    always @(negedge QClk) begin
        instr  <= imem[lastPc[13:2]];    // One cycle after pc
        lastPc <= pc;
    end

    always @(negedge QClk) begin
        // Data only for a read issued one cycle earlier
        readData <= (lastRead && dataMem.exists(lastAddr)) ? dataMem[lastAddr] : '0;
        lastAddr <= dataReq.address;
        lastRead <= !reset && dataReq.read;
        if (!reset && dataReq.write) dataMem[dataReq.address] = dataReq.writeData;
    end

    // Thread of each store taken from its region
    always @(negedge QClk) begin
        if (!reset && (dataReq.read || dataReq.write) && activeMask == '0) begin
            $display("Memory access at %0t before any thread was enabled", $time);
            abortRun();
        end
        if (!reset && dataReq.write) begin
            if (dataReq.address[31:14] != 18'd4 ||
                expQ[dataReq.address[13:12]].size() == 0) begin
                $display("Unexpected store to %h at %0t", dataReq.address, $time);
                abortRun();
            end
            checkStore(expQ[dataReq.address[13:12]].pop_front(), dataReq);
        end
    end

    task automatic writeMask(threadOneHotT mask);
        checkConfig(mask, 1'b0);         // Previous handshake closed
        cfgReq = '{req: 1'b1, enableMask: mask};
        @(negedge QClk);
        checkConfig(mask, 1'b1);
        activeMask = mask;
        cfgReq.req = 1'b0;
        @(negedge QClk);
        checkConfig(mask, 1'b0);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        int snapshot;
        void'($urandom(32'hce8b));
        maxInstr = 0;
        for (int t = 0; t < `CORE_THREADS; t++) buildProgram(t);
        for (int t = 0; t < `CORE_THREADS; t++) runReference(t);
        watchdogCycles = maxInstr * 4 + 1000;   // Plus disable window and margin
        @(negedge QClk);
        while (reset) begin
            if (fetchValid || dataReq.read || dataReq.write) begin
                $display("Core active during reset at %0t", $time);
                abortRun();
            end
            checkConfig('0, 1'b0);
            @(negedge QClk);
        end
        repeat (10) begin                  // Nothing fetches with an empty mask
            @(negedge QClk);
            if (fetchValid) begin
                $display("Fetch with empty mask at %0t", $time);
                abortRun();
            end
        end
        writeMask(4'b1111);
        repeat (200) @(negedge QClk);
        writeMask(4'b1011);                // Park thread 2
        repeat (6) @(negedge QClk);
        snapshot = expQ[2].size();
        repeat (100) @(negedge QClk);
        if (expQ[2].size() != snapshot) begin
            $display("Disabled thread 2 kept storing at %0t", $time);
            abortRun();
        end
        writeMask(4'b1111);
        while (expQ[0].size() + expQ[1].size() + expQ[2].size() + expQ[3].size() > 0)
            @(negedge QClk);
        repeat (20) @(negedge QClk);
        $display("RESULT: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge QClk);
        $display("Timeout after %0d cycles with stores still pending", watchdogCycles);
        abortRun();
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+common
common/rv32IsaPkg.sv
common/core4tPkg.sv
core/threadControl.sv
core/threadScheduler.sv
core/decodeStage.sv
core/registerFile.sv
core/executeStage.sv
core/core4t.sv
sim/clockGen.sv
sim/core4t_assertions.sv
sim/core4t_tb.sv

//--- Makefile
# Verilator build and run of the core4t testbench

TOP = core4t_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o simv --Mdir obj_dir
	./obj_dir/simv | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
